/* hw/csr_params.svh */
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// ------------------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------------------
`define CSR_XLEN             32          // One register word
`define CSR_ADDR_W           12          // CSR address field of the instruction
`define CSR_REG_W            5           // General register index, also the zimm field

// Value returned by a read of mhartid
`define CSR_HART_ID          32'h0000_0000

// ------------------------------------------------------------------------
// Field positions
// ------------------------------------------------------------------------
`define CSR_MSTATUS_MIE      3           // Global machine interrupt enable
`define CSR_MSTATUS_MPIE     7           // MIE as it was before the last trap
`define CSR_MSTATUS_MPP      11          // Low bit of the two bit previous mode

// Enable bits in mie, the pending bits in mip sit at the same places
`define CSR_MIE_MSIE         3
`define CSR_MIE_MTIE         7
`define CSR_MIE_MEIE         11

// mtvec MODE code for vectored interrupts, 0 is direct
`define CSR_MTVEC_VECTORED   1

`endif

/* hw/csr_types_pkg.sv */
`include "csr_params.svh"

package csr_types_pkg;

   // ---------------------------------------------------------------------
   // Plain vectors
   // ---------------------------------------------------------------------
   typedef logic [`CSR_XLEN-1:0]   xlen_t;       // One data word
   typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;   // CSR address
   typedef logic [`CSR_REG_W-1:0]  reg_idx_t;    // Register index or 5 bit immediate

   // Only user and machine mode exist, the encodings follow the ISA
   typedef enum logic [1:0]
   {
      PRIV_U = 2'b00,
      PRIV_M = 2'b11
   } priv_t;

   // funct3 of the SYSTEM opcode, bit 2 selects the immediate form
   typedef enum logic [2:0]
   {
      CSRRW  = 3'b001,
      CSRRS  = 3'b010,
      CSRRC  = 3'b011,
      CSRRWI = 3'b101,
      CSRRSI = 3'b110,
      CSRRCI = 3'b111
   } csr_op_t;

   // ---------------------------------------------------------------------
   // Bundles between the core and the unit and between the blocks
   // ---------------------------------------------------------------------
   typedef struct packed
   {
      logic      valid;
      csr_op_t   op;
      csr_addr_t addr;
      reg_idx_t  rd;
      reg_idx_t  rs1;                             // Also the zimm operand
      xlen_t     rs1_data;
   } csr_req_t;

   typedef struct packed
   {
      logic      valid;
      xlen_t     rd_data;                         // Old CSR value for the register file
      logic      illegal;
      csr_addr_t ill_addr;                        // Zero unless illegal is set
   } csr_resp_t;

   typedef struct packed
   {
      logic      en;
      csr_addr_t addr;
      xlen_t     data;
   } csr_wr_t;

   typedef struct packed
   {
      logic      avail;                           // Address is part of the map
      xlen_t     data;
   } csr_rd_t;

   // Bit 0 is msip so the struct reads like the cause order
   typedef struct packed
   {
      logic      meip;
      logic      mtip;
      logic      msip;
   } irq_lines_t;

   typedef struct packed
   {
      logic      exc;                             // Synchronous exception pulse
      xlen_t     exc_cause;
      xlen_t     epc;
      logic      mret;
   } trap_evt_t;

   typedef struct packed
   {
      logic      take;
      logic      is_irq;
      xlen_t     cause;
      xlen_t     epc;
      logic      mret;
   } trap_upd_t;

   typedef struct packed
   {
      logic       mie_bit;
      priv_t      mpp;
      irq_lines_t enables;
      xlen_t      mtvec;
   } csr_view_t;

   typedef struct packed
   {
      logic      taken;
      xlen_t     trap_pc;
      priv_t     mode;
      xlen_t     mepc;
   } trap_out_t;

endpackage

/* hw/csr_map_pkg.sv */
`include "csr_params.svh"

package csr_map_pkg;

   // Machine CSRs that the unit implements, anything else reads as unavailable
   typedef enum logic [`CSR_ADDR_W-1:0]
   {
      CSR_MSTATUS  = 12'h300,
      CSR_MIE      = 12'h304,
      CSR_MTVEC    = 12'h305,
      CSR_MSCRATCH = 12'h340,
      CSR_MEPC     = 12'h341,
      CSR_MCAUSE   = 12'h342,
      CSR_MIP      = 12'h344,
      CSR_MHARTID  = 12'hF14                      // Read only, bits 11:10 are 3
   } csr_name_e;

   // Machine interrupt causes, listed in the order they win
   typedef enum logic [3:0]
   {
      CAUSE_MSI = 4'd3,
      CAUSE_MTI = 4'd7,
      CAUSE_MEI = 4'd11
   } cause_e;

endpackage

/* hw/csr_access_ctrl.sv */
`timescale 1ns/1ps

module csr_access_ctrl
(
   input  logic                     clk_in,
   input  logic                     rst_n,
   input  csr_types_pkg::csr_req_t  req,
   input  csr_types_pkg::priv_t     mode,
   input  csr_types_pkg::csr_rd_t   rd_lookup,
   output csr_types_pkg::csr_addr_t lookup_addr,
   output csr_types_pkg::csr_wr_t   wr,
   output csr_types_pkg::csr_resp_t resp
);

   import csr_types_pkg::*;

   xlen_t     operand;                            // Register value or zero extended zimm
   xlen_t     new_val;                            // Value the CSR takes if written
   logic      known_op;
   logic      is_swap;
   logic      wants_wr;
   logic      read_only;
   logic      priv_fail;
   logic      illegal;
   csr_resp_t resp_d;

   // ------------------------------------------------------------------------
   // Decode
   // ------------------------------------------------------------------------
   assign lookup_addr = req.addr;                 // Old value comes back in the same cycle

   assign read_only = (req.addr[11:10] == 2'b11); // Top two address bits mark read only
   assign priv_fail = (mode < req.addr[9:8]);     // Bits 9:8 hold the lowest allowed mode

   assign operand = req.op[2] ? xlen_t'(req.rs1) : req.rs1_data;
   assign is_swap = (req.op[1:0] == 2'b01);

   always_comb
   begin
      known_op = 1'b1;
      new_val  = operand;
      case (req.op)
         CSRRW, CSRRWI: new_val = operand;
         CSRRS, CSRRSI: new_val = rd_lookup.data | operand;
         CSRRC, CSRRCI: new_val = rd_lookup.data & ~operand;
         default:       known_op = 1'b0;          // funct3 0 and 4 are not CSR accesses
      endcase
   end

   // Set and clear with x0 or a zero immediate leave the CSR alone
   assign wants_wr = known_op && (is_swap || (req.rs1 != '0));

   // A read only CSR is only illegal when something would be written to it
   assign illegal = known_op &&
                    (priv_fail || !rd_lookup.avail || (wants_wr && read_only));

   // ------------------------------------------------------------------------
   // Write port and response
   // ------------------------------------------------------------------------
   assign wr.en   = req.valid && wants_wr && !illegal;
   assign wr.addr = req.addr;
   assign wr.data = new_val;

   always_comb
   begin
      resp_d          = '0;
      resp_d.valid    = req.valid;
      resp_d.illegal  = req.valid && illegal;
      if (req.valid && illegal)
      begin
         resp_d.ill_addr = req.addr;              // Data stays zero on an illegal access
      end
      else if (req.valid && known_op && !(is_swap && (req.rd == '0)))
      begin
         resp_d.rd_data  = rd_lookup.data;        // A swap to x0 returns nothing
      end
   end

   always_ff @(posedge clk_in or negedge rst_n)
   begin
      if (!rst_n)
         resp <= '0;
      else
         resp <= resp_d;                          // Lands on the edge that writes the CSR
   end

endmodule

/* hw/csr_regs.sv */
`timescale 1ns/1ps

`include "csr_params.svh"

module csr_regs
(
   input  logic                      clk_in,
   input  logic                      rst_n,
   input  csr_types_pkg::csr_addr_t  lookup_addr,
   output csr_types_pkg::csr_rd_t    rd_lookup,
   input  csr_types_pkg::csr_wr_t    wr,
   input  csr_types_pkg::trap_upd_t  upd,
   input  csr_types_pkg::irq_lines_t irq,
   input  csr_types_pkg::priv_t      mode,
   output csr_types_pkg::csr_view_t  view
);

   import csr_types_pkg::*;
   import csr_map_pkg::*;

   // Only the implemented fields are stored, the rest read as zero
   logic                   st_mie;
   logic                   st_mpie;
   priv_t                  st_mpp;
   irq_lines_t             mie_en;
   logic [`CSR_XLEN-1:2]   mtvec_base;
   logic                   mtvec_vec;           // MODE is either direct or vectored
   xlen_t                  mepc;
   xlen_t                  mcause;
   xlen_t                  mscratch;
   xlen_t                  mstatus_word;

   // Places the three lines at their mie and mip positions
   function automatic xlen_t irq_word(input irq_lines_t lines);
      xlen_t w;
      w                  = '0;
      w[`CSR_MIE_MSIE]   = lines.msip;
      w[`CSR_MIE_MTIE]   = lines.mtip;
      w[`CSR_MIE_MEIE]   = lines.meip;
      return w;
   endfunction

   always_comb
   begin
      mstatus_word                       = '0;
      mstatus_word[`CSR_MSTATUS_MIE]     = st_mie;
      mstatus_word[`CSR_MSTATUS_MPIE]    = st_mpie;
      mstatus_word[`CSR_MSTATUS_MPP +: 2] = st_mpp;
   end

   // ------------------------------------------------------------------------
   // Read lookup
   // ------------------------------------------------------------------------
   always_comb
   begin
      rd_lookup.avail = 1'b1;
      case (lookup_addr)
         CSR_MSTATUS:  rd_lookup.data = mstatus_word;
         CSR_MIE:      rd_lookup.data = irq_word(mie_en);
         CSR_MTVEC:    rd_lookup.data = {mtvec_base, 1'b0, mtvec_vec};
         CSR_MSCRATCH: rd_lookup.data = mscratch;
         CSR_MEPC:     rd_lookup.data = mepc;
         CSR_MCAUSE:   rd_lookup.data = mcause;
         CSR_MIP:      rd_lookup.data = irq_word(irq);     // Live view of the lines
         CSR_MHARTID:  rd_lookup.data = `CSR_HART_ID;
         default:
         begin
            rd_lookup.avail = 1'b0;
            rd_lookup.data  = '0;
         end
      endcase
   end

   // ------------------------------------------------------------------------
   // CSR writes, then trap and return updates
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_in or negedge rst_n)
   begin
      if (!rst_n)
      begin
         st_mie     <= 1'b0;
         st_mpie    <= 1'b0;
         st_mpp     <= PRIV_M;
         mie_en     <= '0;
         mtvec_base <= '0;
         mtvec_vec  <= 1'b0;
         mepc       <= '0;
         mcause     <= '0;
         mscratch   <= '0;
      end
      else
      begin
         if (wr.en)
         begin
            case (wr.addr)
               CSR_MSTATUS:
               begin
                  st_mie  <= wr.data[`CSR_MSTATUS_MIE];
                  st_mpie <= wr.data[`CSR_MSTATUS_MPIE];
                  // Supervisor encodings fall back to user
                  st_mpp  <= (wr.data[`CSR_MSTATUS_MPP +: 2] == 2'b11) ? PRIV_M : PRIV_U;
               end
               CSR_MIE:
               begin
                  mie_en.msip <= wr.data[`CSR_MIE_MSIE];
                  mie_en.mtip <= wr.data[`CSR_MIE_MTIE];
                  mie_en.meip <= wr.data[`CSR_MIE_MEIE];
               end
               CSR_MTVEC:
               begin
                  mtvec_base <= wr.data[`CSR_XLEN-1:2];
                  mtvec_vec  <= (wr.data[1:0] == `CSR_MTVEC_VECTORED); // Reserved modes read 0
               end
               CSR_MSCRATCH: mscratch <= wr.data;
               CSR_MEPC:     mepc     <= wr.data;
               CSR_MCAUSE:   mcause   <= wr.data;
               default: ;                         // mip and mhartid keep no state
            endcase
         end

         // Later assignments win, so a trap overrides a CSR write in the same cycle
         if (upd.take)
         begin
            mepc    <= upd.epc;
            mcause  <= {upd.is_irq, upd.cause[`CSR_XLEN-2:0]};
            st_mpie <= st_mie;
            st_mie  <= 1'b0;
            st_mpp  <= mode;                      // Mode the hart trapped from
         end
         else if (upd.mret)
         begin
            st_mie  <= st_mpie;
            st_mpie <= 1'b1;
            st_mpp  <= PRIV_U;
         end
      end
   end

   assign view.mie_bit = st_mie;
   assign view.mpp     = st_mpp;
   assign view.enables = mie_en;
   assign view.mtvec   = {mtvec_base, 1'b0, mtvec_vec};

endmodule

/* hw/trap_ctrl.sv */
`timescale 1ns/1ps

`include "csr_params.svh"

module trap_ctrl
(
   input  logic                      clk_in,
   input  logic                      rst_n,
   input  csr_types_pkg::trap_evt_t  evt,
   input  csr_types_pkg::irq_lines_t irq,
   input  csr_types_pkg::csr_view_t  view,
   output csr_types_pkg::priv_t      mode,
   output csr_types_pkg::trap_upd_t  upd,
   output csr_types_pkg::trap_out_t  tout
);

   import csr_types_pkg::*;
   import csr_map_pkg::*;

   irq_lines_t pending;
   logic       irq_take;
   cause_e     irq_cause;
   logic       take;
   priv_t      mode_q;
   priv_t      mode_d;
   xlen_t      pc_d;
   logic       taken_q;
   xlen_t      pc_q;
   xlen_t      mepc_q;

   // ------------------------------------------------------------------------
   // Interrupt detection
   // ------------------------------------------------------------------------
   assign pending = irq & view.enables;

   // User mode cannot mask machine interrupts, machine mode needs MIE
   assign irq_take = (|pending) && ((mode_q == PRIV_U) || view.mie_bit);

   always_comb
   begin
      if (pending.msip)
         irq_cause = CAUSE_MSI;
      else if (pending.mtip)
         irq_cause = CAUSE_MTI;
      else
         irq_cause = CAUSE_MEI;                   // Only meaningful while irq_take is high
   end

   assign take = evt.exc || irq_take;             // Exception first, then interrupt

   assign upd.take   = take;
   assign upd.is_irq = !evt.exc && irq_take;
   assign upd.cause  = evt.exc ? evt.exc_cause : xlen_t'(irq_cause);
   assign upd.epc    = evt.epc;
   assign upd.mret   = evt.mret && !take;         // A trap in the same cycle drops the mret

   // ------------------------------------------------------------------------
   // Mode FSM
   // ------------------------------------------------------------------------
   always_comb
   begin
      mode_d = mode_q;
      if (take)
         mode_d = PRIV_M;
      else if (evt.mret)
         mode_d = view.mpp;                       // Return to the mode saved at trap entry
   end

   // Direct base, vectored interrupts land four bytes per cause further on
   always_comb
   begin
      pc_d = {view.mtvec[`CSR_XLEN-1:2], 2'b00};
      if (upd.is_irq && (view.mtvec[1:0] == `CSR_MTVEC_VECTORED))
         pc_d = pc_d + (upd.cause << 2);
   end

   always_ff @(posedge clk_in or negedge rst_n)
   begin
      if (!rst_n)
      begin
         mode_q  <= PRIV_M;
         taken_q <= 1'b0;
         pc_q    <= '0;
         mepc_q  <= '0;
      end
      else
      begin
         mode_q  <= mode_d;
         taken_q <= take;                         // One cycle pulse
         if (take)
         begin
            pc_q   <= pc_d;
            mepc_q <= evt.epc;                    // Same edge as mepc in the register block
         end
      end
   end

   assign mode         = mode_q;
   assign tout.taken   = taken_q;
   assign tout.trap_pc = pc_q;
   assign tout.mode    = mode_q;
   assign tout.mepc    = mepc_q;

endmodule

/* hw/csr_unit_top.sv */
`timescale 1ns/1ps

module csr_unit_top
(
   input  logic                      clk_in,
   input  logic                      rst_n,
   input  csr_types_pkg::csr_req_t   req,
   output csr_types_pkg::csr_resp_t  resp,
   input  csr_types_pkg::trap_evt_t  evt,
   input  csr_types_pkg::irq_lines_t irq,
   output csr_types_pkg::trap_out_t  tout
);

   import csr_types_pkg::*;

   csr_addr_t lookup_addr;                        // Decoder to storage, read side
   csr_rd_t   rd_lookup;
   csr_wr_t   wr;
   priv_t     mode;                               // Current privilege from the FSM
   trap_upd_t upd;
   csr_view_t view;                               // Fields the trap logic watches

   csr_access_ctrl u_access
   (
      .clk_in      (clk_in),
      .rst_n       (rst_n),
      .req         (req),
      .mode        (mode),
      .rd_lookup   (rd_lookup),
      .lookup_addr (lookup_addr),
      .wr          (wr),
      .resp        (resp)
   );

   csr_regs u_regs
   (
      .clk_in      (clk_in),
      .rst_n       (rst_n),
      .lookup_addr (lookup_addr),
      .rd_lookup   (rd_lookup),
      .wr          (wr),
      .upd         (upd),
      .irq         (irq),
      .mode        (mode),
      .view        (view)
   );

   trap_ctrl u_trap
   (
      .clk_in      (clk_in),
      .rst_n       (rst_n),
      .evt         (evt),
      .irq         (irq),
      .view        (view),
      .mode        (mode),
      .upd         (upd),
      .tout        (tout)
   );

endmodule

/* tests/csr_unit_model.svh */
`ifndef CSR_UNIT_MODEL_SVH
`define CSR_UNIT_MODEL_SVH

// ------------------------------------------------------------------------
// Reference state of the machine CSRs and the hart mode
// ------------------------------------------------------------------------
logic       m_mie;
logic       m_mpie;
priv_t      m_mpp;
irq_lines_t m_en;                                  // Enable bits of mie
xlen_t      m_mtvec;                               // Stored word, MODE is 0 or 1
xlen_t      m_mepc;
xlen_t      m_mcause;
xlen_t      m_mscratch;
priv_t      m_mode;
xlen_t      m_trap_pc;                             // Last trap target seen on tout
xlen_t      m_out_mepc;                            // Last epc seen on tout

task automatic clear_state();
   m_mie      = 1'b0;
   m_mpie     = 1'b0;
   m_mpp      = PRIV_M;
   m_en       = '0;
   m_mtvec    = '0;
   m_mepc     = '0;
   m_mcause   = '0;
   m_mscratch = '0;
   m_mode     = PRIV_M;                            // The hart leaves reset in machine mode
   m_trap_pc  = '0;
   m_out_mepc = '0;
endtask

// Pending and enable bits share the positions 3, 7 and 11
function automatic xlen_t lines_word(input irq_lines_t l);
   xlen_t w;
   w                = '0;
   w[`CSR_MIE_MSIE] = l.msip;
   w[`CSR_MIE_MTIE] = l.mtip;
   w[`CSR_MIE_MEIE] = l.meip;
   return w;
endfunction

function automatic xlen_t mstatus_word();
   xlen_t w;
   w                         = '0;
   w[`CSR_MSTATUS_MIE]       = m_mie;
   w[`CSR_MSTATUS_MPIE]      = m_mpie;
   w[`CSR_MSTATUS_MPP +: 2]  = m_mpp;
   return w;
endfunction

task automatic read_csr(input csr_addr_t a, input irq_lines_t l,
                        output logic avail, output xlen_t data);
   avail = 1'b1;
   case (a)
      CSR_MSTATUS:  data = mstatus_word();
      CSR_MIE:      data = lines_word(m_en);
      CSR_MTVEC:    data = m_mtvec;
      CSR_MSCRATCH: data = m_mscratch;
      CSR_MEPC:     data = m_mepc;
      CSR_MCAUSE:   data = m_mcause;
      CSR_MIP:      data = lines_word(l);          // mip follows the lines directly
      CSR_MHARTID:  data = `CSR_HART_ID;
      default:
      begin
         avail = 1'b0;
         data  = '0;
      end
   endcase
endtask

task automatic write_csr(input csr_addr_t a, input xlen_t d);
   case (a)
      CSR_MSTATUS:
      begin
         m_mie  = d[`CSR_MSTATUS_MIE];
         m_mpie = d[`CSR_MSTATUS_MPIE];
         // Only 3 selects machine, the other codes map to user
         m_mpp  = (d[`CSR_MSTATUS_MPP +: 2] == 2'b11) ? PRIV_M : PRIV_U;
      end
      CSR_MIE:
      begin
         m_en.msip = d[`CSR_MIE_MSIE];
         m_en.mtip = d[`CSR_MIE_MTIE];
         m_en.meip = d[`CSR_MIE_MEIE];
      end
      CSR_MTVEC:    m_mtvec    = {d[31:2], 1'b0, (d[1:0] == 2'b01)};
      CSR_MSCRATCH: m_mscratch = d;
      CSR_MEPC:     m_mepc     = d;
      CSR_MCAUSE:   m_mcause   = d;
      default: ;                                   // mip and mhartid hold nothing
   endcase
endtask

// An enabled pending line traps in user mode always, in machine mode only with MIE
function automatic logic irq_fires(input irq_lines_t l);
   irq_lines_t hit;
   hit = l & m_en;
   return (|hit) && ((m_mode == PRIV_U) || m_mie);
endfunction

// ------------------------------------------------------------------------
// One clock of the unit, gives the outputs seen after the next edge
// ------------------------------------------------------------------------
task automatic predict_cycle(input csr_req_t r, input trap_evt_t e, input irq_lines_t l,
                             output csr_resp_t er, output trap_out_t et);
   logic       avail;
   xlen_t      old;
   xlen_t      opnd;
   xlen_t      nv;
   logic       swap;
   logic       does_wr;
   logic       bad;
   irq_lines_t hit;
   logic       irq_go;
   logic       go;
   logic [3:0] code;
   priv_t      prev_mode;
   logic       prev_mie;
   logic       prev_mpie;
   priv_t      prev_mpp;
   xlen_t      prev_mtvec;

   read_csr(r.addr, l, avail, old);
   opnd    = r.op[2] ? {27'd0, r.rs1} : r.rs1_data;   // Immediate forms zero extend
   swap    = (r.op == CSRRW) || (r.op == CSRRWI);
   does_wr = swap || (r.rs1 != '0);
   bad     = ((m_mode == PRIV_U) && (r.addr[9:8] != 2'b00)) || !avail ||
             (does_wr && (r.addr[11:10] == 2'b11));
   case (r.op)
      CSRRS, CSRRSI: nv = old | opnd;
      CSRRC, CSRRCI: nv = old & ~opnd;
      default:       nv = opnd;
   endcase

   er = '0;
   if (r.valid)
   begin
      er.valid = 1'b1;
      if (bad)
      begin
         er.illegal  = 1'b1;
         er.ill_addr = r.addr;
      end
      else if (!(swap && (r.rd == '0)))
         er.rd_data = old;
   end

   // Trap choice uses the state before the edge
   hit        = l & m_en;
   irq_go     = irq_fires(l);
   go         = e.exc || irq_go;
   code       = hit.msip ? 4'd3 : (hit.mtip ? 4'd7 : 4'd11);
   prev_mode  = m_mode;
   prev_mie   = m_mie;
   prev_mpie  = m_mpie;
   prev_mpp   = m_mpp;
   prev_mtvec = m_mtvec;

   if (r.valid && does_wr && !bad)
      write_csr(r.addr, nv);

   if (go)
   begin
      m_mepc     = e.epc;
      m_mcause   = e.exc ? {1'b0, e.exc_cause[30:0]} : {1'b1, 27'd0, code};
      m_mpie     = prev_mie;
      m_mie      = 1'b0;
      m_mpp      = prev_mode;
      m_mode     = PRIV_M;
      m_out_mepc = e.epc;
      m_trap_pc  = {prev_mtvec[31:2], 2'b00};
      if (!e.exc && (prev_mtvec[1:0] == 2'b01))
         m_trap_pc = m_trap_pc + {26'd0, code, 2'b00}; // Four bytes per cause
   end
   else if (e.mret)
   begin
      m_mode = prev_mpp;
      m_mie  = prev_mpie;
      m_mpie = 1'b1;
      m_mpp  = PRIV_U;
   end

   et.taken   = go;
   et.trap_pc = m_trap_pc;
   et.mode    = m_mode;
   et.mepc    = m_out_mepc;
endtask

`endif

/* tests/csr_unit_tb.sv */
`timescale 1ns/1ps

`include "csr_params.svh"

module csr_unit_tb;

   import csr_types_pkg::*;
   import csr_map_pkg::*;

   localparam int NUM_OPS    = 4000;
   localparam int CLK_PERIOD = 40;
   localparam int RST_CYCLES = 16;
   localparam int SEED       = 32'h2aa0_687b;

   logic       clk_in;
   logic       rst_n;
   csr_req_t   req;
   csr_resp_t  resp;
   trap_evt_t  evt;
   irq_lines_t irq;
   trap_out_t  tout;

   csr_resp_t  exp_resp;                           // Prediction for the next edge
   trap_out_t  exp_trap;

   `include "csr_unit_model.svh"

   csr_unit_top u_dut
   (
      .clk_in (clk_in),
      .rst_n  (rst_n),
      .req    (req),
      .resp   (resp),
      .evt    (evt),
      .irq    (irq),
      .tout   (tout)
   );

   always #(CLK_PERIOD / 2) clk_in = ~clk_in;

   // ------------------------------------------------------------------------
   // Compare tasks
   // ------------------------------------------------------------------------
   task automatic check_resp(input csr_resp_t got, input csr_resp_t exp);
      if (got != exp)
      begin
         $display("error at %0d ns: response valid=%0b data=%h illegal=%0b addr=%h",
                  $time, got.valid, got.rd_data, got.illegal, got.ill_addr);
         $display("   expected valid=%0b data=%h illegal=%0b addr=%h",
                  exp.valid, exp.rd_data, exp.illegal, exp.ill_addr);
         $display("Some tests failed");
         $fatal(1, "CSR response mismatch");
      end
   endtask

   task automatic check_trap(input trap_out_t got, input trap_out_t exp);
      if (got != exp)
      begin
         $display("error at %0d ns: trap taken=%0b pc=%h mode=%0d mepc=%h",
                  $time, got.taken, got.trap_pc, got.mode, got.mepc);
         $display("   expected taken=%0b pc=%h mode=%0d mepc=%h",
                  exp.taken, exp.trap_pc, exp.mode, exp.mepc);
         $display("Some tests failed");
         $fatal(1, "trap output mismatch");
      end
   endtask

   // ------------------------------------------------------------------------
   // Random stimulus
   // ------------------------------------------------------------------------
   task automatic random_request(output csr_req_t r);
      logic [31:0] rnd;
      rnd = $urandom;
      r   = '0;
      r.valid = 1'b1;
      case (rnd[2:0])
         3'd0, 3'd6: r.op = CSRRW;
         3'd1, 3'd7: r.op = CSRRS;
         3'd2:       r.op = CSRRC;
         3'd3:       r.op = CSRRWI;
         3'd4:       r.op = CSRRSI;
         default:    r.op = CSRRCI;
      endcase
      case (rnd[6:3])
         4'd0, 4'd8:  r.addr = CSR_MSTATUS;         // mstatus often, it steers the traps
         4'd1, 4'd9:  r.addr = CSR_MIE;
         4'd2:        r.addr = CSR_MTVEC;
         4'd3:        r.addr = CSR_MSCRATCH;
         4'd4:        r.addr = CSR_MEPC;
         4'd5:        r.addr = CSR_MCAUSE;
         4'd6:        r.addr = CSR_MIP;
         4'd7, 4'd10: r.addr = CSR_MHARTID;
         4'd11:       r.addr = 12'h301;             // misa is outside the map
         4'd12:       r.addr = 12'h7B0;             // Debug space
         4'd13:       r.addr = 12'hC00;             // Counters were dropped
         default:     r.addr = rnd[31:20];
      endcase
      r.rd       = (rnd[8:7] == 2'b00) ? '0 : rnd[13:9];
      r.rs1      = (rnd[15:14] == 2'b00) ? '0 : rnd[20:16];
      r.rs1_data = $urandom;
   endtask

   task automatic random_event(output trap_evt_t e);
      logic [31:0] rnd;
      logic [31:0] pc;
      rnd = $urandom;
      pc  = $urandom;
      e   = '0;
      e.epc = {pc[31:2], 2'b00};
      if (rnd[4:0] == 5'd0)
      begin
         e.exc       = 1'b1;
         e.exc_cause = {28'd0, rnd[8:5]};
      end
      else if (rnd[4:0] == 5'd1)
         e.mret = 1'b1;
   endtask

   // Lines are levels and only change now and then
   task automatic random_lines(inout irq_lines_t l);
      logic [31:0] rnd;
      rnd = $urandom;
      if (rnd[3:0] == 4'd0)
         l = irq_lines_t'(rnd[6:4] & rnd[9:7]);
   endtask

   // ------------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------------
   initial
   begin
      csr_req_t   req_n;
      trap_evt_t  evt_n;
      irq_lines_t irq_n;
      logic [31:0] rnd;

      clk_in      = 1'b0;
      rst_n       = 1'b0;
      req         = '0;
      evt         = '0;
      irq         = '0;
      irq_n       = '0;
      void'($urandom(SEED));
      clear_state();
      exp_resp      = '0;
      exp_trap      = '0;
      exp_trap.mode = PRIV_M;

      repeat (RST_CYCLES) @(posedge clk_in);
      #1;
      rst_n = 1'b1;

      for (int i = 0; i < NUM_OPS; i++)
      begin
         @(posedge clk_in);
         #1;
         check_resp(resp, exp_resp);               // Outputs of the previous stimulus
         check_trap(tout, exp_trap);

         random_event(evt_n);
         random_lines(irq_n);
         rnd = $urandom;
         // A CSR access never shares a cycle with a trap or a return
         if (evt_n.exc || evt_n.mret || irq_fires(irq_n) || (rnd[3:0] == 4'd0))
            req_n = '0;
         else
            random_request(req_n);

         req = req_n;
         evt = evt_n;
         irq = irq_n;
         predict_cycle(req_n, evt_n, irq_n, exp_resp, exp_trap);
      end

      @(posedge clk_in);
      #1;
      check_resp(resp, exp_resp);
      check_trap(tout, exp_trap);

      $display("All tests passed");
      $finish;
   end

   // Four clock periods per operation is far more than the run needs
   initial
   begin
      #(NUM_OPS * CLK_PERIOD * 4 + RST_CYCLES * CLK_PERIOD);
      $display("watchdog expired before the test sequence finished");
      $display("Some tests failed");
      $fatal(1, "timeout");
   end

endmodule

/* files.f */
+incdir+hw
+incdir+tests
hw/csr_types_pkg.sv
hw/csr_map_pkg.sv
hw/csr_access_ctrl.sv
hw/csr_regs.sv
hw/trap_ctrl.sv
hw/csr_unit_top.sv
tests/csr_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 --top-module csr_unit_tb -f files.f --Mdir obj_dir -o csr_unit_sim

# The simulator exits nonzero on $fatal, the search below decides the result
sim_out=$(./obj_dir/csr_unit_sim 2>&1) || true
echo "$sim_out"

if grep -q "All tests passed" <<< "$sim_out"; then
   echo "Simulation PASSED"
   exit 0
fi

echo "Simulation FAILED"
exit 1
